//--- div_pkg.sv
package div_pkg;

  // operand and result width
  localparam int XLEN = 64;

  // reorder buffer entries, tag counts 0 through ROB_SIZE
  localparam int ROB_SIZE = 16;
  localparam int TAG_W = $clog2(ROB_SIZE + 1);

  // issue queue depth, power of two so pointers wrap on their own
  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

  // divider step counter, one step per quotient bit
  localparam int CNT_W = $clog2(XLEN);

  // divide opcodes
  typedef enum logic [1:0] {
    DIV_OP_DIVU = 2'b00,
    DIV_OP_REMU = 2'b01,
    DIV_OP_DIV  = 2'b10,
    DIV_OP_REM  = 2'b11
  } div_op_e;

  // dispatched divide operation, operands already ready
  typedef struct packed {
    div_op_e           op;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   dividend;
    logic [XLEN-1:0]   divisor;
  } div_req_t;

  // finished operation handed to the rest of execute
  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    div_op_e           op;
    logic [XLEN-1:0]   value;
    logic              div_by_zero;
  } div_rsp_t;

endpackage

//--- div_issue_queue.sv
`timescale 1ns/100ps

module div_issue_queue (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  // dispatch side
  input  logic              push_valid_i,
  input  div_pkg::div_req_t push_req_i,
  output logic              push_ready_o,
  // divide stage side
  input  logic              pop_stall_i,
  output logic              pop_valid_o,
  output div_pkg::div_req_t pop_req_o
);
  import div_pkg::*;

  // entry storage, payload only
  div_req_t mem_r [QUEUE_DEPTH];

  logic [QPTR_W-1:0] wr_ptr_r;
  logic [QPTR_W-1:0] rd_ptr_r;
  logic [QCNT_W-1:0] count_r;

  logic push_fire;
  logic pop_fire;

  // full check, ready drops with four entries held
  assign push_ready_o = (count_r != QCNT_W'(QUEUE_DEPTH));
  // anything stored is visible one cycle after its push
  assign pop_valid_o  = (count_r != '0);
  assign pop_req_o    = mem_r[rd_ptr_r];

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & ~pop_stall_i;

  // write port
  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_r[wr_ptr_r] <= push_req_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else if (flush_i) begin
      // rob restore, drop everything including a push this cycle
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      // push and pop together leave the count alone
      case ({push_fire, pop_fire})
        2'b10: begin
          count_r <= count_r + 1'b1;
        end
        2'b01: begin
          count_r <= count_r - 1'b1;
        end
        default: begin
          count_r <= count_r;
        end
      endcase
    end
  end

endmodule

//--- div_core.sv
`timescale 1ns/100ps

module div_core (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     flush_i,
  input  logic                     start_i,
  input  div_pkg::div_op_e         op_i,
  input  logic [div_pkg::XLEN-1:0] dividend_i,
  input  logic [div_pkg::XLEN-1:0] divisor_i,
  output logic                     done_o,
  output logic [div_pkg::XLEN-1:0] value_o,
  output logic                     div_by_zero_o
);
  import div_pkg::*;

  typedef enum logic [1:0] {CORE_IDLE, CORE_RUN, CORE_FIX, CORE_DONE} core_state_e;

  core_state_e      state_r;
  logic [CNT_W-1:0] step_r;

  // datapath registers
  logic [XLEN-1:0] rem_r;
  logic [XLEN-1:0] quo_r;
  logic [XLEN-1:0] dvs_r;
  logic [XLEN-1:0] value_r;
  logic            neg_q_r;
  logic            neg_r_r;
  logic            rem_sel_r;
  logic            dbz_r;

  logic            signed_op;
  logic            rem_op;
  logic            neg_a;
  logic            neg_b;
  logic [XLEN-1:0] abs_a;
  logic [XLEN-1:0] abs_b;
  logic [XLEN:0]   shifted;
  logic [XLEN:0]   diff;
  logic            ge;
  logic [XLEN-1:0] q_fix;
  logic [XLEN-1:0] r_fix;

  // operand prep at start
  always_comb begin
    signed_op = (op_i == DIV_OP_DIV) || (op_i == DIV_OP_REM);
    rem_op    = (op_i == DIV_OP_REMU) || (op_i == DIV_OP_REM);
    neg_a     = signed_op & dividend_i[XLEN-1];
    neg_b     = signed_op & divisor_i[XLEN-1];
    // most negative value maps to 2**63, still fits unsigned
    abs_a     = neg_a ? -dividend_i : dividend_i;
    abs_b     = neg_b ? -divisor_i : divisor_i;
  end

  // one restoring step, dividend bits shift in from the quotient reg
  always_comb begin
    shifted = {rem_r, quo_r[XLEN-1]};
    diff    = shifted - {1'b0, dvs_r};
    ge      = (shifted >= {1'b0, dvs_r});
  end

  // sign fix-up and forced results
  always_comb begin
    q_fix = dbz_r ? '1 : (neg_q_r ? -quo_r : quo_r);
    // zero divisor leaves abs dividend in rem, so the sign restores it
    r_fix = neg_r_r ? -rem_r : rem_r;
  end

  // sequencing
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      state_r <= CORE_IDLE;
      step_r  <= '0;
    end else if (flush_i) begin
      state_r <= CORE_IDLE;
      step_r  <= '0;
    end else if (start_i) begin
      state_r <= CORE_RUN;
      step_r  <= '0;
    end else begin
      case (state_r)
        CORE_RUN: begin
          step_r <= step_r + 1'b1;
          // last of the 64 steps
          if (step_r == CNT_W'(XLEN - 1)) begin
            state_r <= CORE_FIX;
          end
        end
        CORE_FIX:  state_r <= CORE_DONE;
        CORE_DONE: state_r <= CORE_IDLE;
        default:   state_r <= CORE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_r     <= '0;
      quo_r     <= abs_a;
      dvs_r     <= abs_b;
      neg_q_r   <= neg_a ^ neg_b;
      neg_r_r   <= neg_a;
      rem_sel_r <= rem_op;
      dbz_r     <= (divisor_i == '0);
    end else if (state_r == CORE_RUN) begin
      rem_r <= ge ? diff[XLEN-1:0] : shifted[XLEN-1:0];
      quo_r <= {quo_r[XLEN-2:0], ge};
    end else if (state_r == CORE_FIX) begin
      value_r <= rem_sel_r ? r_fix : q_fix;
    end
  end

  assign done_o        = (state_r == CORE_DONE);
  assign value_o       = value_r;
  assign div_by_zero_o = dbz_r;

endmodule

//--- div_issue_stage.sv
`timescale 1ns/100ps

module div_issue_stage (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  // from the issue queue
  input  logic              issue_valid_i,
  input  div_pkg::div_req_t issue_req_i,
  output logic              issue_stall_o,
  // toward the rest of execute
  input  logic              can_go_i,
  output logic              result_valid_o,
  output div_pkg::div_rsp_t result_o
);
  import div_pkg::*;

  typedef enum logic [1:0] {STAGE_WAIT, STAGE_BUSY, STAGE_DONE} stage_state_e;

  stage_state_e state_r;
  stage_state_e state_n;

  logic            accept;
  logic            core_start_r;
  logic            core_done;
  logic [XLEN-1:0] core_value;
  logic            core_dbz;

  // held request and result
  div_req_t        req_r;
  logic [XLEN-1:0] value_r;
  logic            dbz_r;

  // take a request only while idle
  assign accept        = (state_r == STAGE_WAIT) & issue_valid_i;
  assign issue_stall_o = ~accept;

  always_comb begin
    state_n = state_r;
    case (state_r)
      STAGE_WAIT: begin
        if (accept) begin
          state_n = STAGE_BUSY;
        end
      end
      STAGE_BUSY: begin
        if (core_done) begin
          state_n = STAGE_DONE;
        end
      end
      STAGE_DONE: begin
        if (can_go_i) begin
          state_n = STAGE_WAIT;
        end
      end
      default: state_n = STAGE_WAIT;
    endcase
  end

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      state_r      <= STAGE_WAIT;
      core_start_r <= 1'b0;
    end else if (flush_i) begin
      state_r      <= STAGE_WAIT;
      core_start_r <= 1'b0;
    end else begin
      state_r      <= state_n;
      // start one cycle after accept, operands come from req_r
      core_start_r <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_r <= issue_req_i;
    end
    if (core_done) begin
      value_r <= core_value;
      dbz_r   <= core_dbz;
    end
  end

  div_core u_core (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .start_i       (core_start_r),
    .op_i          (req_r.op),
    .dividend_i    (req_r.dividend),
    .divisor_i     (req_r.divisor),
    .done_o        (core_done),
    .value_o       (core_value),
    .div_by_zero_o (core_dbz)
  );

  // result is stable for the whole done state
  always_comb begin
    result_o.tag         = req_r.tag;
    result_o.op          = req_r.op;
    result_o.value       = value_r;
    result_o.div_by_zero = dbz_r;
  end

  assign result_valid_o = (state_r == STAGE_DONE);

endmodule

//--- div_exec_unit.sv
`timescale 1ns/100ps

module div_exec_unit (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              flush_i,
  // dispatch
  input  logic              dispatch_valid_i,
  input  div_pkg::div_req_t dispatch_req_i,
  output logic              dispatch_ready_o,
  // result
  input  logic              can_go_i,
  output logic              result_valid_o,
  output div_pkg::div_rsp_t result_o
);
  import div_pkg::*;

  // queue to stage
  logic     issue_valid;
  logic     issue_stall;
  div_req_t issue_req;

  div_issue_queue u_queue (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .flush_i      (flush_i),
    .push_valid_i (dispatch_valid_i),
    .push_req_i   (dispatch_req_i),
    .push_ready_o (dispatch_ready_o),
    .pop_stall_i  (issue_stall),
    .pop_valid_o  (issue_valid),
    .pop_req_o    (issue_req)
  );

  div_issue_stage u_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .issue_valid_i  (issue_valid),
    .issue_req_i    (issue_req),
    .issue_stall_o  (issue_stall),
    .can_go_i       (can_go_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

//--- div_exec_unit_props.sv
`timescale 1ns/100ps

module div_issue_stage_props (
  input logic              clk_i,
  input logic              reset_i,
  input logic              flush_i,
  input logic              can_go_i,
  input logic              issue_stall_o,
  input logic              result_valid_o,
  input div_pkg::div_rsp_t result_o
);

  // nothing presented in the cycle after a reset edge
  a_reset_idle: assert property (@(posedge clk_i) reset_i |=> !result_valid_o)
    else $error("result_valid_o high in the cycle after reset");

  // held result stays put until taken
  a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (result_valid_o && !can_go_i && !flush_i) |=> (result_valid_o && $stable(result_o)))
    else $error("result_o changed or dropped while can_go_i was low");

  // an accepted request leaves the waiting state, so never two takes back to back
  a_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    !issue_stall_o |=> issue_stall_o)
    else $error("issue_stall_o low in the cycle after an accept");

  // flush kills any presented result
  a_flush: assert property (@(posedge clk_i) disable iff (reset_i)
    flush_i |=> !result_valid_o)
    else $error("result_valid_o high in the cycle after flush_i");

endmodule

bind div_issue_stage div_issue_stage_props u_props (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .flush_i        (flush_i),
  .can_go_i       (can_go_i),
  .issue_stall_o  (issue_stall_o),
  .result_valid_o (result_valid_o),
  .result_o       (result_o)
);

//--- tb_div_exec_unit.sv
`timescale 1ns/100ps

module tb_div_exec_unit;
  import div_pkg::*;

  localparam int TIMEOUT = 2000;

  typedef enum {GO_ON, GO_OFF, GO_RAND} go_mode_e;

  logic     clk_i;
  logic     reset_i;
  logic     flush_i;
  logic     dispatch_valid_i;
  div_req_t dispatch_req_i;
  logic     dispatch_ready_o;
  logic     can_go_i;
  logic     result_valid_o;
  div_rsp_t result_o;

  logic [31:0]      lfsr_r;
  go_mode_e         go_mode;
  int               go_left;
  logic             go_level;
  logic [TAG_W-1:0] next_tag;
  div_rsp_t         exp_q[$];
  div_rsp_t         exp_rsp;
  int               n_checks;
  int               val_errs;
  int               other_errs;
  int               i;

  div_exec_unit dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
    lfsr_r = {lfsr_r[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[62:0], lfsr_bit()};
    return v;
  endfunction

  function automatic div_req_t build_req(input div_op_e op, input logic [XLEN-1:0] a,
                                         input logic [XLEN-1:0] b);
    div_req_t r;
    r = '{op: op, tag: next_tag, dividend: a, divisor: b};
    // tags wrap like rob slots
    next_tag = (next_tag == TAG_W'(ROB_SIZE)) ? '0 : next_tag + 1'b1;
    return r;
  endfunction

  function automatic div_req_t make_req(input logic signed_ops);
    logic [1:0]      sel;
    logic [XLEN-1:0] b;
    sel = rand_bits(2);
    // small, half width or full width divisors, small ones can be zero
    if (sel == 2'd0) begin
      b = rand_bits(4);
    end else if (sel == 2'd1) begin
      b = rand_bits(32);
    end else begin
      b = rand_bits(64);
    end
    if (signed_ops) begin
      if (lfsr_bit()) begin
        b = -b;
      end
    end
    return build_req(div_op_e'({signed_ops, lfsr_bit()}), rand_bits(64), b);
  endfunction

  // reference rules, independent of the datapath
  function automatic div_rsp_t model(input div_req_t req);
    logic [XLEN-1:0] q;
    logic [XLEN-1:0] m;
    logic            sgn;
    sgn = (req.op == DIV_OP_DIV) || (req.op == DIV_OP_REM);
    if (req.divisor == '0) begin
      q = '1;
      m = req.dividend;
    end else if (sgn && req.dividend == {1'b1, {(XLEN-1){1'b0}}} && req.divisor == '1) begin
      q = req.dividend;
      m = '0;
    end else if (sgn) begin
      q = $signed(req.dividend) / $signed(req.divisor);
      m = $signed(req.dividend) % $signed(req.divisor);
    end else begin
      q = req.dividend / req.divisor;
      m = req.dividend % req.divisor;
    end
    return '{tag: req.tag, op: req.op, div_by_zero: (req.divisor == '0),
             value: (req.op == DIV_OP_DIVU || req.op == DIV_OP_DIV) ? q : m};
  endfunction

  task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h exp %h", name, got, exp);
      val_errs++;
    end
  endtask

  task automatic report_and_finish();
    $display("checks %0d, value errors %0d, other errors %0d", n_checks, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0 && n_checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // one clock, can_go_i follows the current mode
  task automatic tick();
    @(posedge clk_i);
    if (go_mode == GO_RAND) begin
      if (go_left == 0) begin
        go_level = lfsr_bit();
        go_left  = int'(rand_bits(4));
      end else begin
        go_left--;
      end
    end
    can_go_i <= (go_mode == GO_ON) || (go_mode == GO_RAND && go_level);
  endtask

  // 0 result valid, 1 dispatch ready, 2 model queue drained
  function automatic logic cond_met(input int sel);
    return (sel == 0) ? result_valid_o : (sel == 1) ? dispatch_ready_o : (exp_q.size() == 0);
  endfunction

  task automatic wait_for(input int sel, input string what);
    int t;
    t = 0;
    @(negedge clk_i);
    while (!cond_met(sel) && t < TIMEOUT) begin
      tick();
      @(negedge clk_i);
      t++;
    end
    if (!cond_met(sel)) begin
      $display("timed out waiting for %s", what);
      other_errs++;
      report_and_finish();
    end
  endtask

  task automatic send(input div_req_t req);
    tick();
    dispatch_valid_i <= 1'b1;
    dispatch_req_i   <= req;
    wait_for(1, "dispatch_ready_o");
    // transfer edge
    tick();
    dispatch_valid_i <= 1'b0;
  endtask

  // scoreboard, samples on the same edge the dut uses
  always @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      exp_q.delete();
    end else begin
      if (result_valid_o && can_go_i) begin
        if (exp_q.size() == 0) begin
          $display("result taken with no operation outstanding, tag %h", result_o.tag);
          other_errs++;
        end else begin
          exp_rsp = exp_q.pop_front();
          n_checks++;
          check_field("result_o.tag", 64'(result_o.tag), 64'(exp_rsp.tag));
          check_field("result_o.op", 64'(result_o.op), 64'(exp_rsp.op));
          check_field("result_o.value", result_o.value, exp_rsp.value);
          check_field("result_o.div_by_zero", 64'(result_o.div_by_zero),
                      64'(exp_rsp.div_by_zero));
        end
      end
      if (dispatch_valid_i && dispatch_ready_o) exp_q.push_back(model(dispatch_req_i));
    end
  end

  initial begin
    lfsr_r           = 32'd87949;
    reset_i          = 1'b1;
    flush_i          = 1'b0;
    dispatch_valid_i = 1'b0;
    dispatch_req_i   = '0;
    can_go_i         = 1'b0;
    go_mode          = GO_ON;
    go_left          = 0;
    go_level         = 1'b0;
    next_tag         = '0;
    n_checks         = 0;
    val_errs         = 0;
    other_errs       = 0;
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    // unsigned then signed with mixed signs
    for (i = 0; i < 12; i++) send(make_req(1'b0));
    for (i = 0; i < 12; i++) send(make_req(1'b1));
    // most negative over minus one
    send(build_req(DIV_OP_DIV, {1'b1, {(XLEN-1){1'b0}}}, '1));
    send(build_req(DIV_OP_REM, {1'b1, {(XLEN-1){1'b0}}}, '1));
    // zero divisor on every opcode
    for (i = 0; i < 4; i++) send(build_req(div_op_e'(i), rand_bits(64), '0));
    // random back pressure, order and tags kept
    go_mode = GO_RAND;
    for (i = 0; i < 20; i++) send(make_req(lfsr_bit()));
    go_mode = GO_ON;
    wait_for(2, "results after back pressure");
    // one in the stage plus four queued fills everything
    go_mode = GO_OFF;
    for (i = 0; i < 5; i++) send(make_req(1'b0));
    @(negedge clk_i);
    if (dispatch_ready_o !== 1'b0) begin
      $display("FAIL dispatch_ready_o got %h exp %h", dispatch_ready_o, 1'b0);
      val_errs++;
    end
    wait_for(0, "result_valid_o with a full queue");
    go_mode = GO_ON;
    wait_for(1, "dispatch_ready_o after a result was taken");
    wait_for(2, "results of the full queue");
    // flush mid operation, nothing from before it may come out
    for (i = 0; i < 3; i++) send(make_req(lfsr_bit()));
    repeat (30) tick();
    go_mode = GO_OFF;
    tick();
    flush_i <= 1'b1;
    tick();
    flush_i <= 1'b0;
    go_mode = GO_RAND;
    for (i = 0; i < 8; i++) send(make_req(lfsr_bit()));
    go_mode = GO_ON;
    wait_for(2, "results after flush");
    report_and_finish();
  end

endmodule

//--- div_exec_unit.f
div_pkg.sv
div_issue_queue.sv
div_core.sv
div_issue_stage.sv
div_exec_unit.sv
div_exec_unit_props.sv
tb_div_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
# build with assertions on, run, then look for the pass line in the log
cd "$(dirname "$0")" && rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_div_exec_unit \
  -f div_exec_unit.f -o tb_div_exec_unit > build.log 2>&1 &&
./obj_dir/tb_div_exec_unit > sim.log 2>&1 ||
echo "build or simulation stopped early, see build.log and sim.log"
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
